//--- sources.f
u409Pkg.sv
eClockGen.sv
addressDecode.sv
overlayControl.sv
cycleControl.sv
u409Top.sv
u409_sva.sv
tb_u409.sv

//--- tb_u409.sv
//////////////////////////////////////////////////
// U409 bus glue testbench
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_u409;

    import u409Pkg::*;

    localparam int ROM_WAIT = ROM_WAIT_DEF;
    localparam int ECLK_DIV = ECLK_DIV_DEF;

    logic    clk40;
    logic    rst;
    logic    ts;
    addrHi_t addr;
    logic    rw;
    logic    ovlData;
    logic    romEn;
    logic    ciaSpace;
    logic    nCiaCs0;
    logic    nCiaCs1;
    logic    nRamSpace;
    logic    nRegSpace;
    logic    ta;
    logic    ovl;
    // Expected overlay flag
    logic    expOvl;
    integer  seed;

    u409Top uut (
        .clk40(clk40), .rst(rst), .ts(ts), .addr(addr), .rw(rw), .ovlData(ovlData),
        .romEn(romEn), .ciaSpace(ciaSpace), .nCiaCs0(nCiaCs0), .nCiaCs1(nCiaCs1),
        .nRamSpace(nRamSpace), .nRegSpace(nRegSpace), .ta(ta), .ovl(ovl)
    );

    // 4 ns clock
    always #2 clk40 = ~clk40;

    //////////////////////////////////////////////////
    // Helpers and compares
    //////////////////////////////////////////////////

    // Drive and sample point, 1 ns after the rising edge
    task automatic nextCycle;
        @(posedge clk40);
        #1;
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "signal mismatch");
        end
    endtask

    task automatic checkAddr(input addrHi_t actual, input addrHi_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic checkWait(input waitCnt_t actual, input waitCnt_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "wait count mismatch");
        end
    endtask

    task automatic timeoutStop(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "wait expired");
    endtask

    // Region rules of Z2 space, bit order rom cia cs0 cs1 ram reg
    function automatic logic [5:0] refDecode(input addrHi_t a, input logic ovlNow);
        logic z2;
        logic rom;
        logic cia;
        z2  = (a[31:24] == 8'h00);
        rom = z2 && (ovlNow ? (a[23:21] == 3'b000) : (a[23:19] == 5'b11111));
        cia = z2 && (a[23:16] == 8'hBF);
        return {rom, cia, cia && a[12], cia && a[13],
                z2 && !ovlNow && (a[23:21] == 3'b000), z2 && (a[23:16] == 8'hDF)};
    endfunction

    //////////////////////////////////////////////////
    // Bus cycle tasks
    //////////////////////////////////////////////////

    // One-clock ts, returns in the decode cycle
    task automatic busCycle(input addrHi_t a, input logic isRead, input logic dataBit);
        ts      = 1'b1;
        addr    = a;
        rw      = isRead;
        ovlData = dataBit;
        nextCycle();
        ts = 1'b0;
        checkAddr(uut.decode.addrReg, a, "captured address");
        checkBit(ta, 1'b0, "ta in decode cycle");
    endtask

    // ta lands ROM_WAIT clocks after decode
    task automatic romFinish;
        int cycles;
        cycles = 0;
        while (ta !== 1'b1) begin
            if (cycles >= ROM_WAIT + 2) begin
                timeoutStop("no ta for the ROM cycle");
            end
            nextCycle();
            cycles++;
        end
        checkWait(waitCnt_t'(cycles), waitCnt_t'(ROM_WAIT), "ROM ta delay");
        nextCycle();
        checkBit(ta, 1'b0, "ta after ROM ack");
    endtask

    // Chip selects low until ta, then the overlay may update
    task automatic ciaFinish(input logic cs0, input logic cs1, input logic isWrite,
                             input logic dataBit);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            if (cycles >= ECLK_DIV + 2) begin
                timeoutStop("no ta for the CIA cycle within the E-clock window");
            end
            nextCycle();
            cycles++;
            checkBit(ciaSpace, 1'b1, "ciaSpace");
            done = ta;
            checkBit(nCiaCs0, done | !cs0, "nCiaCs0");
            checkBit(nCiaCs1, done | !cs1, "nCiaCs1");
        end
        if (isWrite && cs0) begin
            expOvl = dataBit;
        end
        nextCycle();
        checkBit(ta, 1'b0, "ta after CIA ack");
        checkBit(ovl, expOvl, "ovl");
    endtask

    // Unanswered region, strobes gone and no ta
    task automatic idleFinish(input int window);
        for (int i = 0; i < window; i++) begin
            nextCycle();
            checkBit(ta, 1'b0, "ta");
            checkBit(nCiaCs0, 1'b1, "nCiaCs0");
            checkBit(nCiaCs1, 1'b1, "nCiaCs1");
            checkBit(nRamSpace, 1'b1, "nRamSpace");
            checkBit(nRegSpace, 1'b1, "nRegSpace");
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testReset;
        checkBit(ovl, 1'b1, "ovl after reset");
        checkBit(ta, 1'b0, "ta after reset");
        checkBit(nCiaCs0, 1'b1, "nCiaCs0 after reset");
        checkBit(nCiaCs1, 1'b1, "nCiaCs1 after reset");
        checkBit(nRamSpace, 1'b1, "nRamSpace after reset");
        checkBit(nRegSpace, 1'b1, "nRegSpace after reset");
        // Reset vector fetch through the overlay
        busCycle(20'h00000, 1'b1, 1'b0);
        checkBit(romEn, 1'b1, "romEn at zero");
        romFinish();
    endtask

    task automatic testUpperWindow;
        busCycle(20'h00F80, 1'b1, 1'b0);
        checkBit(romEn, 1'b0, "romEn in upper window");
        idleFinish(ECLK_DIV + 4);
    endtask

    task automatic testOverlayClear;
        // CIA-A write, data bit 0 low
        busCycle(20'h00BF1, 1'b0, 1'b0);
        ciaFinish(1'b1, 1'b0, 1'b1, 1'b0);
        busCycle(20'h00000, 1'b1, 1'b0);
        checkBit(nRamSpace, 1'b0, "nRamSpace at zero");
        checkBit(romEn, 1'b0, "romEn at zero");
        idleFinish(ROM_WAIT + 2);
        busCycle(20'h00F80, 1'b1, 1'b0);
        checkBit(romEn, 1'b1, "romEn in upper window");
        romFinish();
    endtask

    task automatic testChipSelects;
        // Reads carry bit 0 high, overlay must stay down
        busCycle(20'h00BF1, 1'b1, 1'b1);
        ciaFinish(1'b1, 1'b0, 1'b0, 1'b1);
        busCycle(20'h00BF2, 1'b1, 1'b1);
        ciaFinish(1'b0, 1'b1, 1'b0, 1'b1);
        busCycle(20'h00BF3, 1'b1, 1'b1);
        ciaFinish(1'b1, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic testOtherRegions;
        busCycle(20'h00DF0, 1'b1, 1'b0);
        checkBit(nRegSpace, 1'b0, "nRegSpace in DF space");
        checkBit(ciaSpace, 1'b0, "ciaSpace in DF space");
        idleFinish(ROM_WAIT + 2);
        // Zorro 3 addresses, CIA and RAM patterns above 16 MB
        busCycle(20'h01BF3, 1'b1, 1'b0);
        checkBit(ciaSpace, 1'b0, "ciaSpace outside Z2");
        idleFinish(ECLK_DIV + 4);
        busCycle(20'h10000, 1'b1, 1'b0);
        checkBit(nRamSpace, 1'b1, "nRamSpace outside Z2");
        checkBit(romEn, 1'b0, "romEn outside Z2");
        idleFinish(ROM_WAIT + 2);
    endtask

    task automatic testRandom;
        addrHi_t     a;
        logic [5:0]  exp;
        int unsigned pick;
        for (int i = 0; i < 20; i++) begin
            a    = addrHi_t'($random(seed));
            pick = $random(seed);
            // Steer most picks into a Z2 region
            case (pick % 6)
                0: a[31:16] = 16'h00BF;
                1: a[31:16] = 16'h00DF;
                2: a[31:21] = 11'h000;
                3: a[31:19] = 13'h001F;
                4: a[31:24] = 8'h00;
                default: ;
            endcase
            exp = refDecode(a, expOvl);
            busCycle(a, 1'b1, 1'b1);
            checkBit(romEn, exp[5], "romEn");
            checkBit(ciaSpace, exp[4], "ciaSpace");
            checkBit(nRamSpace, !exp[1], "nRamSpace");
            checkBit(nRegSpace, !exp[0], "nRegSpace");
            if (exp[5]) begin
                romFinish();
            end else if (exp[4]) begin
                ciaFinish(exp[3], exp[2], 1'b0, 1'b1);
            end else begin
                idleFinish(ROM_WAIT + 2);
            end
            checkBit(ovl, expOvl, "ovl");
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        seed    = 84805;
        clk40   = 1'b0;
        rst     = 1'b1;
        ts      = 1'b0;
        addr    = '0;
        rw      = 1'b1;
        ovlData = 1'b0;
        expOvl  = 1'b1;
        repeat (4) @(posedge clk40);
        #1;
        rst = 1'b0;
        testReset();
        testUpperWindow();
        testOverlayClear();
        testChipSelects();
        testOtherRegions();
        testRandom();
        nextCycle();
        if (uut.cycle.cycleChecks.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Assertion failures: %0d", uut.cycle.cycleChecks.failCount);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- u409_sva.sv
//////////////////////////////////////////////////
// Cycle controller assertions
//////////////////////////////////////////////////

`timescale 1ns/1ns

module u409Sva (
    input logic                 clk40,
    input logic                 rst,
    input u409Pkg::cycleState_t state,
    input logic                 romHit,
    input logic                 ciaHit,
    input logic                 ta,
    input logic                 nCiaCs0,
    input logic                 nCiaCs1
);

    import u409Pkg::*;

    // Number of failed checks so far
    int failCount = 0;

    // No CIA is selected while the controller waits for a decode
    csIdle: assert property (@(posedge clk40) disable iff (rst)
        (state == idle) |-> (nCiaCs0 && nCiaCs1))
        else begin
            failCount++;
            $error("CIA chip select low while idle");
        end

    // ta is a single clock pulse
    taSingle: assert property (@(posedge clk40) disable iff (rst)
        ta |=> !ta)
        else begin
            failCount++;
            $error("ta high for two clocks");
        end

    // ta only ends a cycle whose decode hit ROM or CIA space
    // Decoder levels hold until the next ts, which waits for ta
    taOrigin: assert property (@(posedge clk40) disable iff (rst)
        ta |-> $past(romHit || ciaHit))
        else begin
            failCount++;
            $error("ta without a ROM or CIA hit");
        end

endmodule

bind cycleControl u409Sva cycleChecks (
    .clk40(clk40), .rst(rst), .state(state), .romHit(romHit), .ciaHit(ciaHit),
    .ta(ta), .nCiaCs0(nCiaCs0), .nCiaCs1(nCiaCs1)
);

//--- u409Top.sv
//////////////////////////////////////////////////
// U409 bus glue top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module u409Top #(
    parameter u409Pkg::waitCnt_t ROM_WAIT = u409Pkg::ROM_WAIT_DEF,
    parameter u409Pkg::divCnt_t  ECLK_DIV = u409Pkg::ECLK_DIV_DEF
) (
    input  logic             clk40,
    input  logic             rst,
    input  logic             ts,
    input  u409Pkg::addrHi_t addr,
    input  logic             rw,
    input  logic             ovlData,
    output logic             romEn,
    output logic             ciaSpace,
    output logic             nCiaCs0,
    output logic             nCiaCs1,
    output logic             nRamSpace,
    output logic             nRegSpace,
    output logic             ta,
    output logic             ovl
);

    // Decoder to controller
    logic decodeValid;
    logic romHit;
    logic ciaHit;
    logic cs0Sel;
    logic cs1Sel;
    logic cycleWrite;
    logic cycleOvlData;
    // Divider and overlay handshakes
    logic ciaEnable;
    logic ciaWriteDone;

    eClockGen #(.ECLK_DIV(ECLK_DIV)) eClock (
        .clk40(clk40), .rst(rst), .ciaEnable(ciaEnable)
    );

    addressDecode decode (
        .clk40(clk40), .rst(rst), .ts(ts), .addr(addr), .rw(rw),
        .ovlDataIn(ovlData), .ovl(ovl), .decodeValid(decodeValid),
        .romHit(romHit), .ciaHit(ciaHit), .cs0Sel(cs0Sel), .cs1Sel(cs1Sel),
        .cycleWrite(cycleWrite), .cycleOvlData(cycleOvlData), .romEn(romEn),
        .ciaSpace(ciaSpace), .nRamSpace(nRamSpace), .nRegSpace(nRegSpace)
    );

    // Overlay feeds back into the decoder
    overlayControl overlay (
        .clk40(clk40), .rst(rst), .ciaWriteDone(ciaWriteDone),
        .cycleOvlData(cycleOvlData), .ovl(ovl)
    );

    cycleControl #(.ROM_WAIT(ROM_WAIT)) cycle (
        .clk40(clk40), .rst(rst), .decodeValid(decodeValid),
        .romHit(romHit), .ciaHit(ciaHit), .cs0Sel(cs0Sel), .cs1Sel(cs1Sel),
        .cycleWrite(cycleWrite), .ciaEnable(ciaEnable), .ta(ta),
        .nCiaCs0(nCiaCs0), .nCiaCs1(nCiaCs1), .ciaWriteDone(ciaWriteDone)
    );

endmodule

//--- cycleControl.sv
//////////////////////////////////////////////////
// ROM and CIA cycle controller
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cycleControl #(
    parameter u409Pkg::waitCnt_t ROM_WAIT = u409Pkg::ROM_WAIT_DEF
) (
    input  logic clk40,
    input  logic rst,
    input  logic decodeValid,
    input  logic romHit,
    input  logic ciaHit,
    input  logic cs0Sel,
    input  logic cs1Sel,
    input  logic cycleWrite,
    input  logic ciaEnable,
    output logic ta,
    output logic nCiaCs0,
    output logic nCiaCs1,
    output logic ciaWriteDone
);

    import u409Pkg::*;

    // romWait runs ROM_WAIT-1 clocks, ack lands ROM_WAIT after decodeValid
    localparam waitCnt_t ROM_LOAD = (ROM_WAIT > 2) ? waitCnt_t'(ROM_WAIT - 2) : '0;
    // One wait state or less goes straight to ack
    localparam logic ROM_DIRECT = (ROM_WAIT < 2);

    cycleState_t state;
    cycleState_t stateNext;
    waitCnt_t    waitCnt;
    waitCnt_t    waitNext;
    logic        cs0Latch;
    logic        cs1Latch;
    logic        writeLatch;
    logic        cs0Next;
    logic        cs1Next;
    logic        startCycle;

    // A decode only counts while idle, a busy ts is dropped
    assign startCycle = (state == idle) && decodeValid;

    //////////////////////////////////////////////////
    // Cycle attributes
    //////////////////////////////////////////////////

    // Chip selects and direction held for the whole CIA cycle
    // since the decoder may move on at the next ts
    always_ff @(posedge clk40) begin
        if (startCycle) begin
            cs0Latch   <= cs0Sel;
            cs1Latch   <= cs1Sel;
            writeLatch <= cycleWrite;
        end
    end

    // Selects as seen by the next state
    assign cs0Next = (state == idle) ? cs0Sel : cs0Latch;
    assign cs1Next = (state == idle) ? cs1Sel : cs1Latch;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        waitNext  = waitCnt;
        case (state)
            idle: begin
                if (decodeValid) begin
                    if (romHit) begin
                        if (ROM_DIRECT) begin
                            stateNext = ack;
                        end else begin
                            stateNext = romWait;
                            waitNext  = ROM_LOAD;
                        end
                    end else if (ciaHit) begin
                        stateNext = ciaWait;
                    end
                    // Other regions get no ta here, stay idle
                end
            end
            romWait: begin
                if (waitCnt == '0) begin
                    stateNext = ack;
                end else begin
                    waitNext = waitCnt - 1'b1;
                end
            end
            ciaWait: begin
                // Finish on the first E-clock window
                if (ciaEnable) begin
                    stateNext = ack;
                end
            end
            ack: begin
                stateNext = idle;
            end
            default: begin
                stateNext = idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // State and registered outputs
    //////////////////////////////////////////////////

    // Outputs are decoded from the next state so that
    // they line up with the state register
    always_ff @(posedge clk40) begin
        if (rst) begin
            state        <= idle;
            waitCnt      <= '0;
            ta           <= 1'b0;
            nCiaCs0      <= 1'b1;
            nCiaCs1      <= 1'b1;
            ciaWriteDone <= 1'b0;
        end else begin
            state   <= stateNext;
            waitCnt <= waitNext;
            // Single ta per answered cycle
            ta      <= (stateNext == ack);
            // Low through ciaWait, released with ta
            nCiaCs0 <= !((stateNext == ciaWait) && cs0Next);
            nCiaCs1 <= !((stateNext == ciaWait) && cs1Next);
            // CIA-A write ending now, overlay loads next clock
            ciaWriteDone <= (state == ciaWait) && ciaEnable && cs0Latch && writeLatch;
        end
    end

endmodule

//--- overlayControl.sv
//////////////////////////////////////////////////
// ROM overlay register
//////////////////////////////////////////////////

`timescale 1ns/1ns

module overlayControl (
    input  logic clk40,
    input  logic rst,
    input  logic ciaWriteDone,
    input  logic cycleOvlData,
    output logic ovl
);

    //////////////////////////////////////////////////
    // Overlay flag
    //////////////////////////////////////////////////

    // Reset brings the overlay up so the CPU fetches its
    // reset vectors from ROM at address zero
    //
    // Boot code drops it by writing CIA-A port A with bit 0 low
    // A later write with bit 0 high puts it back

    always_ff @(posedge clk40) begin
        if (rst) begin
            ovl <= 1'b1;
        end else if (ciaWriteDone) begin
            // Bit captured at ts of the finishing write
            ovl <= cycleOvlData;
        end
    end

    // The rest of the CIA-A port bits live in the CIA itself
    // Only the overlay copy is kept here for the decoder

endmodule

//--- addressDecode.sv
//////////////////////////////////////////////////
// Zorro 2 address decoder
//////////////////////////////////////////////////

`timescale 1ns/1ns

module addressDecode (
    input  logic             clk40,
    input  logic             rst,
    input  logic             ts,
    input  u409Pkg::addrHi_t addr,
    input  logic             rw,
    input  logic             ovlDataIn,
    input  logic             ovl,
    output logic             decodeValid,
    output logic             romHit,
    output logic             ciaHit,
    output logic             cs0Sel,
    output logic             cs1Sel,
    output logic             cycleWrite,
    output logic             cycleOvlData,
    output logic             romEn,
    output logic             ciaSpace,
    output logic             nRamSpace,
    output logic             nRegSpace
);

    import u409Pkg::*;

    addrHi_t addrReg;
    logic    rwReg;
    logic    ovlDataReg;
    logic    addrLoaded;
    logic    z2Space;
    logic    romSel;
    logic    ciaSel;
    logic    ramSel;
    logic    regSel;

    //////////////////////////////////////////////////
    // Capture on transfer start
    //////////////////////////////////////////////////

    // Address, direction and data bit 0 of the current cycle
    always_ff @(posedge clk40) begin
        if (ts) begin
            addrReg    <= addr;
            rwReg      <= rw;
            ovlDataReg <= ovlDataIn;
        end
    end

    // decodeValid follows ts by one clock
    // addrLoaded keeps the level outputs quiet until the first cycle
    always_ff @(posedge clk40) begin
        if (rst) begin
            decodeValid <= 1'b0;
            addrLoaded  <= 1'b0;
        end else begin
            decodeValid <= ts;
            addrLoaded  <= addrLoaded | ts;
        end
    end

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    // Only the low 16 MB responds, Zorro 3 space is left alone
    assign z2Space = (addrReg[31:24] == 8'h00);

    // Boot image at the reset vector while the overlay is up, else at F80000
    assign romSel = z2Space && (ovl ? (addrReg[23:21] == 3'b000)
                                    : (addrReg[23:19] == 5'b11111));

    assign ciaSel = z2Space && (addrReg[23:16] == CIA_REGION);
    // Chip RAM shows through only once the overlay is gone
    assign ramSel = z2Space && !ovl && (addrReg[23:21] == 3'b000);
    assign regSel = z2Space && (addrReg[23:16] == REG_REGION);

    // Levels for the cycle controller, sampled with decodeValid
    assign romHit = romSel;
    assign ciaHit = ciaSel;
    // CIA-A on A12, CIA-B on A13, both may be picked at once
    assign cs0Sel = ciaSel && addrReg[12];
    assign cs1Sel = ciaSel && addrReg[13];
    assign cycleWrite   = !rwReg;
    assign cycleOvlData = ovlDataReg;

    // Held until the next ts
    assign romEn    = addrLoaded && romSel;
    assign ciaSpace = addrLoaded && ciaSel;

    // One-clock strobes to the chip-bus controller
    assign nRamSpace = !(decodeValid && ramSel);
    assign nRegSpace = !(decodeValid && regSel);

endmodule

//--- eClockGen.sv
//////////////////////////////////////////////////
// E-clock window generator
//////////////////////////////////////////////////

`timescale 1ns/1ns

module eClockGen #(
    parameter u409Pkg::divCnt_t ECLK_DIV = u409Pkg::ECLK_DIV_DEF
) (
    input  logic clk40,
    input  logic rst,
    output logic ciaEnable
);

    import u409Pkg::*;

    // Reload value, counter runs ECLK_DIV states from load down to zero
    localparam divCnt_t DIV_LOAD = divCnt_t'(ECLK_DIV - 1);

    divCnt_t divCnt;
    logic    terminal;

    // Terminal count of the divider
    assign terminal = (divCnt == '0);

    //////////////////////////////////////////////////
    // Divider counter
    //////////////////////////////////////////////////

    // Down counter, restarts from the load value at zero
    always_ff @(posedge clk40) begin
        if (rst) begin
            divCnt <= DIV_LOAD;
        end else if (terminal) begin
            divCnt <= DIV_LOAD;
        end else begin
            divCnt <= divCnt - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Enable pulse
    //////////////////////////////////////////////////

    // One clock high per period
    // Registered, so the first pulse lands ECLK_DIV clocks after reset
    always_ff @(posedge clk40) begin
        if (rst) begin
            ciaEnable <= 1'b0;
        end else begin
            ciaEnable <= terminal;
        end
    end

    // This stands in for the 68000 E phase the 8520s expect
    // The cycle controller only needs the window edge, not the clock itself

endmodule

//--- u409Pkg.sv
//////////////////////////////////////////////////
// U409 bus glue shared types
//////////////////////////////////////////////////

package u409Pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    // Upper CPU address bits seen by the decoder
    typedef logic [31:12] addrHi_t;

    // ROM wait-state counter
    typedef logic [3:0] waitCnt_t;

    // E-clock divider counter
    typedef logic [5:0] divCnt_t;

    //////////////////////////////////////////////////
    // Defaults for the top-level parameters
    //////////////////////////////////////////////////

    // Kickstart ROM needs three extra clocks at 40 MHz
    localparam waitCnt_t ROM_WAIT_DEF = 4'd3;

    // 40 MHz down to the 2 MHz CIA window
    localparam divCnt_t ECLK_DIV_DEF = 6'd20;

    // Region codes in address bits 23 to 16
    localparam logic [7:0] CIA_REGION = 8'hBF;
    localparam logic [7:0] REG_REGION = 8'hDF;

    //////////////////////////////////////////////////
    // Cycle controller states
    //////////////////////////////////////////////////

    // Idle waits for a decode, romWait counts wait states,
    // ciaWait holds chip selects until the E-clock window,
    // ack is the single ta cycle
    typedef enum logic [1:0] {
        idle,
        romWait,
        ciaWait,
        ack
    } cycleState_t;

endpackage
